// File: ntPkg.sv
// name table store shared definitions
package ntPkg;

    // ram geometry
    localparam int RamDepth = 512;
    localparam int AddrW = $clog2(RamDepth);
    localparam int DataW = 32;
    localparam int BeW = DataW / 8;

    // screen geometry, 32x30 tiles
    localparam int TileCols = 32;
    localparam int TileRows = 30;
    localparam int ColW = $clog2(TileCols);
    localparam int RowW = $clog2(TileRows);

    // name region, one byte per tile
    localparam logic [AddrW-1:0] NameBase = AddrW'(0);
    localparam int NameWords = TileCols * TileRows / BeW;
    localparam int NameByteW = $clog2(NameWords * BeW);

    // attribute region, one byte per 4x4 tile block
    localparam logic [AddrW-1:0] AttrBase = AddrW'(240);
    localparam int AttrWords = 16;
    localparam int AttrByteW = $clog2(AttrWords * BeW);

    // owner of the ram write port
    typedef enum logic [1:0] {
        GNT_NONE = 2'd0,
        GNT_CPU  = 2'd1,
        GNT_NAME = 2'd2,
        GNT_ATTR = 2'd3
    } wrGrant_e;

    // loader FSM
    typedef enum logic [1:0] {
        LD_IDLE = 2'd0,
        LD_NAME = 2'd1,
        LD_ATTR = 2'd2
    } loadState_e;

endpackage

// File: nameTableRam.sv
// name table block ram
`timescale 1ns/1ps

module nameTableRam (
    input  logic                      clk_sel,
    // single write port, reversed byte lanes
    input  logic [ntPkg::BeW-1:0]     we,
    input  logic [ntPkg::AddrW-1:0]   wrAddr,
    input  logic [ntPkg::DataW-1:0]   wrData,
    // cpu read port
    input  logic [ntPkg::AddrW-1:0]   cpuRdAddr,
    output logic [ntPkg::DataW-1:0]   cpuRdData,
    // tile fetch read ports
    input  logic [ntPkg::AddrW-1:0]   nameRdAddr,
    output logic [ntPkg::DataW-1:0]   nameRdData,
    input  logic [ntPkg::AddrW-1:0]   attrRdAddr,
    output logic [ntPkg::DataW-1:0]   attrRdData
);

    // storage, contents undefined until loaded
    logic [ntPkg::DataW-1:0] mem [ntPkg::RamDepth];

    // byte writes
    // we[3] owns bits 7:0, we[0] owns bits 31:24
    always_ff @(posedge clk_sel) begin
        for (int b = 0; b < ntPkg::BeW; b++) begin
            if (we[ntPkg::BeW-1-b]) begin
                mem[wrAddr][8*b +: 8] <= wrData[8*b +: 8];
            end
        end
    end

    // registered reads
    // same-word write in this cycle returns the old word
    always_ff @(posedge clk_sel) begin
        cpuRdData  <= mem[cpuRdAddr];
        nameRdData <= mem[nameRdAddr];
        attrRdData <= mem[attrRdAddr];
    end

endmodule

// File: ntWriteArbiter.sv
// fixed priority write arbiter
`timescale 1ns/1ps

module ntWriteArbiter (
    input  logic                      clk_sel,
    input  logic                      rstN,
    // cpu writer, any enable bit is a strobe
    input  logic [ntPkg::BeW-1:0]     cpuWe,
    input  logic [ntPkg::AddrW-1:0]   cpuWrAddr,
    input  logic [ntPkg::DataW-1:0]   cpuWrData,
    // loader writers, always full words
    input  logic                      nameWrStb,
    input  logic [ntPkg::AddrW-1:0]   nameWrAddr,
    input  logic [ntPkg::DataW-1:0]   nameWrData,
    input  logic                      attrWrStb,
    input  logic [ntPkg::AddrW-1:0]   attrWrAddr,
    input  logic [ntPkg::DataW-1:0]   attrWrData,
    // ram write port
    output logic [ntPkg::BeW-1:0]     ramWe,
    output logic [ntPkg::AddrW-1:0]   ramAddr,
    output logic [ntPkg::DataW-1:0]   ramWrData,
    output ntPkg::wrGrant_e           grant,
    output logic                      wrOverflow
);

    // writer index 0 cpu, 1 name, 2 attr; lower index wins
    logic [2:0]               stb;
    logic [ntPkg::BeW-1:0]    inBe   [3];
    logic [ntPkg::AddrW-1:0]  inAddr [3];
    logic [ntPkg::DataW-1:0]  inData [3];

    // one pending entry per writer
    logic [2:0]               pendV;
    logic [ntPkg::BeW-1:0]    pendBe   [3];
    logic [ntPkg::AddrW-1:0]  pendAddr [3];
    logic [ntPkg::DataW-1:0]  pendData [3];

    // candidate per writer: pending entry first, else the new strobe
    logic [2:0]               effV;
    logic [ntPkg::BeW-1:0]    effBe   [3];
    logic [ntPkg::AddrW-1:0]  effAddr [3];
    logic [ntPkg::DataW-1:0]  effData [3];
    logic [2:0]               take;
    ntPkg::wrGrant_e          grantNext;

    always_comb begin
        stb       = {attrWrStb, nameWrStb, |cpuWe};
        inBe[0]   = cpuWe;
        inAddr[0] = cpuWrAddr;
        inData[0] = cpuWrData;
        inBe[1]   = '1;
        inAddr[1] = nameWrAddr;
        inData[1] = nameWrData;
        inBe[2]   = '1;
        inAddr[2] = attrWrAddr;
        inData[2] = attrWrData;

        for (int i = 0; i < 3; i++) begin
            effV[i]    = pendV[i] | stb[i];
            effBe[i]   = pendV[i] ? pendBe[i]   : inBe[i];
            effAddr[i] = pendV[i] ? pendAddr[i] : inAddr[i];
            effData[i] = pendV[i] ? pendData[i] : inData[i];
        end

        // fixed priority pick
        take      = 3'b000;
        grantNext = ntPkg::GNT_NONE;
        if (effV[0]) begin
            take[0]   = 1'b1;
            grantNext = ntPkg::GNT_CPU;
        end else if (effV[1]) begin
            take[1]   = 1'b1;
            grantNext = ntPkg::GNT_NAME;
        end else if (effV[2]) begin
            take[2]   = 1'b1;
            grantNext = ntPkg::GNT_ATTR;
        end

        // write lands on the next edge
        ramWe     = '0;
        ramAddr   = '0;
        ramWrData = '0;
        for (int i = 0; i < 3; i++) begin
            if (take[i]) begin
                ramWe     = effBe[i];
                ramAddr   = effAddr[i];
                ramWrData = effData[i];
            end
        end
    end

    // control state
    always_ff @(posedge clk_sel or negedge rstN) begin
        if (!rstN) begin
            pendV      <= 3'b000;
            grant      <= ntPkg::GNT_NONE;
            wrOverflow <= 1'b0;
        end else begin
            // grant shows the writer whose word is now readable
            grant <= grantNext;
            for (int i = 0; i < 3; i++) begin
                if (take[i]) begin
                    // drained pending entry refills from a same-cycle strobe
                    pendV[i] <= pendV[i] & stb[i];
                end else begin
                    pendV[i] <= effV[i];
                end
                // buffer stays full, new strobe is lost
                if (pendV[i] && stb[i] && !take[i]) begin
                    wrOverflow <= 1'b1;
                end
            end
        end
    end

    // pending payload
    always_ff @(posedge clk_sel) begin
        for (int i = 0; i < 3; i++) begin
            if (stb[i] && (pendV[i] ? take[i] : !take[i])) begin
                pendBe[i]   <= inBe[i];
                pendAddr[i] <= inAddr[i];
                pendData[i] <= inData[i];
            end
        end
    end

endmodule

// File: flashLoader.sv
// flash stream loader
`timescale 1ns/1ps

module flashLoader (
    input  logic                      clk_sel,
    input  logic                      rstN,
    input  logic                      loadStart,
    input  logic                      loadStb,
    input  logic [ntPkg::DataW-1:0]   loadData,
    // name region writer
    output logic                      nameWrStb,
    output logic [ntPkg::AddrW-1:0]   nameWrAddr,
    output logic [ntPkg::DataW-1:0]   nameWrData,
    // attribute region writer
    output logic                      attrWrStb,
    output logic [ntPkg::AddrW-1:0]   attrWrAddr,
    output logic [ntPkg::DataW-1:0]   attrWrData,
    output logic                      loadDone,
    output ntPkg::loadState_e         state
);

    // word offset inside the current region
    logic [ntPkg::AddrW-1:0] wordCnt;
    // last attribute word went out this cycle
    logic                    lastWord;

    always_ff @(posedge clk_sel or negedge rstN) begin
        if (!rstN) begin
            state     <= ntPkg::LD_IDLE;
            wordCnt   <= '0;
            nameWrStb <= 1'b0;
            attrWrStb <= 1'b0;
            lastWord  <= 1'b0;
            loadDone  <= 1'b0;
        end else begin
            // strobes last one cycle
            nameWrStb <= 1'b0;
            attrWrStb <= 1'b0;
            lastWord  <= 1'b0;
            loadDone  <= lastWord;
            if (loadStart) begin
                // rewind, even mid load
                state   <= ntPkg::LD_NAME;
                wordCnt <= '0;
            end else if (loadStb) begin
                case (state)
                    ntPkg::LD_NAME: begin
                        nameWrStb <= 1'b1;
                        if (wordCnt == ntPkg::NameWords - 1) begin
                            state   <= ntPkg::LD_ATTR;
                            wordCnt <= '0;
                        end else begin
                            wordCnt <= wordCnt + 1'b1;
                        end
                    end
                    ntPkg::LD_ATTR: begin
                        attrWrStb <= 1'b1;
                        if (wordCnt == ntPkg::AttrWords - 1) begin
                            state    <= ntPkg::LD_IDLE;
                            wordCnt  <= '0;
                            lastWord <= 1'b1;
                        end else begin
                            wordCnt <= wordCnt + 1'b1;
                        end
                    end
                    // idle ignores stray strobes
                    default: ;
                endcase
            end
        end
    end

    // payload follows the strobe by one cycle
    always_ff @(posedge clk_sel) begin
        if (loadStb) begin
            nameWrAddr <= ntPkg::NameBase + wordCnt;
            nameWrData <= loadData;
            attrWrAddr <= ntPkg::AttrBase + wordCnt;
            attrWrData <= loadData;
        end
    end

endmodule

// File: tileFetch.sv
// tile index and palette lookup
`timescale 1ns/1ps

module tileFetch (
    input  logic                      clk_sel,
    input  logic                      rstN,
    input  logic                      fetchStb,
    input  logic [ntPkg::RowW-1:0]    tileRow,
    input  logic [ntPkg::ColW-1:0]    tileCol,
    // ram read ports, data one cycle after address
    output logic [ntPkg::AddrW-1:0]   nameRdAddr,
    input  logic [ntPkg::DataW-1:0]   nameRdData,
    output logic [ntPkg::AddrW-1:0]   attrRdAddr,
    input  logic [ntPkg::DataW-1:0]   attrRdData,
    output logic                      tileValid,
    output logic [7:0]                tileIndex,
    output logic [1:0]                tilePalette
);

    // stage one byte positions
    logic [ntPkg::NameByteW-1:0] nameByte;
    logic [ntPkg::AttrByteW-1:0] attrByte;

    // stage one registers
    logic       s1Valid;
    logic [1:0] s1NameLane;
    logic [1:0] s1AttrLane;
    logic [2:0] s1Shift;

    // stage two byte picks
    logic [7:0] attrSel;

    // one byte per tile, row major
    assign nameByte = ntPkg::NameByteW'(tileRow * ntPkg::TileCols + tileCol);
    // one attribute byte per 4x4 tile block
    assign attrByte = ntPkg::AttrByteW'((tileRow >> 2) * (ntPkg::TileCols / 4)
                                        + (tileCol >> 2));

    // addresses go straight to the ram so the data lines up with stage one
    assign nameRdAddr = ntPkg::NameBase
                        + ntPkg::AddrW'(nameByte[ntPkg::NameByteW-1:2]);
    assign attrRdAddr = ntPkg::AttrBase
                        + ntPkg::AddrW'(attrByte[ntPkg::AttrByteW-1:2]);

    always_ff @(posedge clk_sel or negedge rstN) begin
        if (!rstN) begin
            s1Valid   <= 1'b0;
            tileValid <= 1'b0;
        end else begin
            s1Valid   <= fetchStb;
            tileValid <= s1Valid;
        end
    end

    // lane and quadrant travel alongside the read
    always_ff @(posedge clk_sel) begin
        s1NameLane <= nameByte[1:0];
        s1AttrLane <= attrByte[1:0];
        // quadrant shift, 4 for lower half, 2 for right half
        s1Shift    <= {tileRow[1], tileCol[1], 1'b0};
    end

    // byte n of a word sits at bits 8n
    assign attrSel = attrRdData[8*s1AttrLane +: 8];

    always_ff @(posedge clk_sel) begin
        tileIndex   <= nameRdData[8*s1NameLane +: 8];
        tilePalette <= 2'(attrSel >> s1Shift);
    end

endmodule

// File: nameTableTop.sv
// background name table store
`timescale 1ns/1ps

module nameTableTop (
    input  logic                      clk_sel,
    input  logic                      rstN,
    // cpu port
    input  logic [ntPkg::BeW-1:0]     cpuWe,
    input  logic [ntPkg::AddrW-1:0]   cpuWrAddr,
    input  logic [ntPkg::DataW-1:0]   cpuWrData,
    input  logic [ntPkg::AddrW-1:0]   cpuRdAddr,
    output logic [ntPkg::DataW-1:0]   cpuRdData,
    // flash stream
    input  logic                      loadStart,
    input  logic                      loadStb,
    input  logic [ntPkg::DataW-1:0]   loadData,
    output logic                      loadDone,
    // write port status
    output logic                      wrOverflow,
    output ntPkg::wrGrant_e           grant,
    // tile fetch
    input  logic                      fetchStb,
    input  logic [ntPkg::RowW-1:0]    tileRow,
    input  logic [ntPkg::ColW-1:0]    tileCol,
    output logic                      tileValid,
    output logic [7:0]                tileIndex,
    output logic [1:0]                tilePalette
);

    // loader to arbiter
    logic                     nameWrStb;
    logic [ntPkg::AddrW-1:0]  nameWrAddr;
    logic [ntPkg::DataW-1:0]  nameWrData;
    logic                     attrWrStb;
    logic [ntPkg::AddrW-1:0]  attrWrAddr;
    logic [ntPkg::DataW-1:0]  attrWrData;
    // loader FSM, for debug visibility
    ntPkg::loadState_e        loadState;

    // arbiter to ram
    logic [ntPkg::BeW-1:0]    ramWe;
    logic [ntPkg::AddrW-1:0]  ramAddr;
    logic [ntPkg::DataW-1:0]  ramWrData;

    // tile fetch reads
    logic [ntPkg::AddrW-1:0]  nameRdAddr;
    logic [ntPkg::DataW-1:0]  nameRdData;
    logic [ntPkg::AddrW-1:0]  attrRdAddr;
    logic [ntPkg::DataW-1:0]  attrRdData;

    flashLoader i_flashLoader (
        .clk_sel    (clk_sel),
        .rstN       (rstN),
        .loadStart  (loadStart),
        .loadStb    (loadStb),
        .loadData   (loadData),
        .nameWrStb  (nameWrStb),
        .nameWrAddr (nameWrAddr),
        .nameWrData (nameWrData),
        .attrWrStb  (attrWrStb),
        .attrWrAddr (attrWrAddr),
        .attrWrData (attrWrData),
        .loadDone   (loadDone),
        .state      (loadState)
    );

    ntWriteArbiter i_ntWriteArbiter (
        .clk_sel    (clk_sel),
        .rstN       (rstN),
        .cpuWe      (cpuWe),
        .cpuWrAddr  (cpuWrAddr),
        .cpuWrData  (cpuWrData),
        .nameWrStb  (nameWrStb),
        .nameWrAddr (nameWrAddr),
        .nameWrData (nameWrData),
        .attrWrStb  (attrWrStb),
        .attrWrAddr (attrWrAddr),
        .attrWrData (attrWrData),
        .ramWe      (ramWe),
        .ramAddr    (ramAddr),
        .ramWrData  (ramWrData),
        .grant      (grant),
        .wrOverflow (wrOverflow)
    );

    nameTableRam i_nameTableRam (
        .clk_sel    (clk_sel),
        .we         (ramWe),
        .wrAddr     (ramAddr),
        .wrData     (ramWrData),
        .cpuRdAddr  (cpuRdAddr),
        .cpuRdData  (cpuRdData),
        .nameRdAddr (nameRdAddr),
        .nameRdData (nameRdData),
        .attrRdAddr (attrRdAddr),
        .attrRdData (attrRdData)
    );

    tileFetch i_tileFetch (
        .clk_sel     (clk_sel),
        .rstN        (rstN),
        .fetchStb    (fetchStb),
        .tileRow     (tileRow),
        .tileCol     (tileCol),
        .nameRdAddr  (nameRdAddr),
        .nameRdData  (nameRdData),
        .attrRdAddr  (attrRdAddr),
        .attrRdData  (attrRdData),
        .tileValid   (tileValid),
        .tileIndex   (tileIndex),
        .tilePalette (tilePalette)
    );

endmodule

// File: nameTableTb.sv
// name table store testbench
`timescale 1ns/1ps

module nameTableTb;

    // testbench step kinds
    typedef enum logic [2:0] {
        OP_LOAD,
        OP_CPUWR,
        OP_CPURD,
        OP_FETCH,
        OP_RACE,
        OP_BURST
    } tbOp_e;

    typedef struct packed {
        tbOp_e       op;
        logic [8:0]  addr;
        logic [31:0] data;
        logic [3:0]  be;
        logic [4:0]  row;
        logic [4:0]  col;
        logic        expOvf;
    } step_t;

    // strobes plus idle gaps, full readback, margin
    localparam int LoadCycles = 2 * 256 + 2 * 256 + 64;
    localparam int BurstLen = 8;

    logic                     clk_sel;
    logic                     rstN;
    logic [ntPkg::BeW-1:0]    cpuWe;
    logic [ntPkg::AddrW-1:0]  cpuWrAddr;
    logic [ntPkg::DataW-1:0]  cpuWrData;
    logic [ntPkg::AddrW-1:0]  cpuRdAddr;
    logic [ntPkg::DataW-1:0]  cpuRdData;
    logic                     loadStart;
    logic                     loadStb;
    logic [ntPkg::DataW-1:0]  loadData;
    logic                     loadDone;
    logic                     wrOverflow;
    ntPkg::wrGrant_e          grant;
    logic                     fetchStb;
    logic [ntPkg::RowW-1:0]   tileRow;
    logic [ntPkg::ColW-1:0]   tileCol;
    logic                     tileValid;
    logic [7:0]               tileIndex;
    logic [1:0]               tilePalette;

    // mirror of the ram contents
    logic [31:0] shadow [512];
    step_t       steps [$];
    integer      seed = 86;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    int          donePulses = 0;

    // expected fetch results, [1] is due this cycle
    logic        pipeV   [2];
    logic [7:0]  pipeIdx [2];
    logic [1:0]  pipePal [2];

    nameTableTop i_nameTableTop (
        .clk_sel     (clk_sel),
        .rstN        (rstN),
        .cpuWe       (cpuWe),
        .cpuWrAddr   (cpuWrAddr),
        .cpuWrData   (cpuWrData),
        .cpuRdAddr   (cpuRdAddr),
        .cpuRdData   (cpuRdData),
        .loadStart   (loadStart),
        .loadStb     (loadStb),
        .loadData    (loadData),
        .loadDone    (loadDone),
        .wrOverflow  (wrOverflow),
        .grant       (grant),
        .fetchStb    (fetchStb),
        .tileRow     (tileRow),
        .tileCol     (tileCol),
        .tileValid   (tileValid),
        .tileIndex   (tileIndex),
        .tilePalette (tilePalette)
    );

    always #5 clk_sel = ~clk_sel;

    // run limit
    always @(posedge clk_sel) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycleCount);
            $display("Test failed");
            $fatal(1, "run aborted");
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %h actual %h", $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    // byte-lane rule, enable bit 3 owns the low byte
    task automatic mergeShadow(input logic [8:0] addr, input logic [3:0] be,
                               input logic [31:0] data);
        if (be[3]) shadow[addr][7:0] = data[7:0];
        if (be[2]) shadow[addr][15:8] = data[15:8];
        if (be[1]) shadow[addr][23:16] = data[23:16];
        if (be[0]) shadow[addr][31:24] = data[31:24];
    endtask

    // tile index and palette straight from the shadow
    task automatic expectTile(input logic [4:0] row, input logic [4:0] col,
                              output logic [7:0] idx, output logic [1:0] pal);
        int          nIdx;
        int          aIdx;
        int          shift;
        logic [31:0] aWord;
        logic [7:0]  aByte;
        nIdx  = int'(row) * 32 + int'(col);
        idx   = 8'(shadow[ntPkg::NameBase + nIdx / 4] >> (8 * (nIdx % 4)));
        aIdx  = (int'(row) / 4) * 8 + int'(col) / 4;
        aWord = shadow[ntPkg::AttrBase + aIdx / 4];
        aByte = 8'(aWord >> (8 * (aIdx % 4)));
        shift = 4 * int'(row[1]) + 2 * int'(col[1]);
        pal   = 2'(aByte >> shift);
    endtask

    // advance to the next falling edge, check fetch output, drop strobes
    task automatic nextCycle();
        @(negedge clk_sel);
        if (loadDone === 1'b1) donePulses++;
        checkValue("tileValid", 32'(pipeV[1]), 32'(tileValid));
        if (pipeV[1]) begin
            checkValue("tileIndex", 32'(pipeIdx[1]), 32'(tileIndex));
            checkValue("tilePalette", 32'(pipePal[1]), 32'(tilePalette));
        end
        pipeV[1]   = pipeV[0];
        pipeIdx[1] = pipeIdx[0];
        pipePal[1] = pipePal[0];
        pipeV[0]   = 1'b0;
        fetchStb   = 1'b0;
        loadStart  = 1'b0;
        loadStb    = 1'b0;
        cpuWe      = '0;
    endtask

    // wait until the write port has gone quiet
    task automatic drainWrites();
        nextCycle();
        nextCycle();
        while (grant != ntPkg::GNT_NONE) nextCycle();
    endtask

    task automatic readCheck(input logic [8:0] addr);
        cpuRdAddr = addr;
        nextCycle();
        checkValue("cpuRdData", shadow[addr], cpuRdData);
    endtask

    task automatic writeCpu(input logic [8:0] addr, input logic [3:0] be,
                            input logic [31:0] data);
        cpuWe     = be;
        cpuWrAddr = addr;
        cpuWrData = data;
        mergeShadow(addr, be, data);
        nextCycle();
        drainWrites();
    endtask

    // 256 words with an idle cycle after each strobe
    task automatic loadAll();
        logic [31:0] data;
        loadStart = 1'b1;
        nextCycle();
        checkValue("loadState", 32'(ntPkg::LD_NAME), 32'(i_nameTableTop.loadState));
        donePulses = 0;
        for (int w = 0; w < 256; w++) begin
            data     = $random(seed);
            loadStb  = 1'b1;
            loadData = data;
            shadow[w] = data;
            nextCycle();
            nextCycle();
            // name region holds the first 240 words
            if (w == 239) begin
                checkValue("loadState", 32'(ntPkg::LD_ATTR), 32'(i_nameTableTop.loadState));
            end
        end
        // done one cycle after the last attribute strobe
        checkValue("loadDone", 1, 32'(loadDone));
        checkValue("loadState", 32'(ntPkg::LD_IDLE), 32'(i_nameTableTop.loadState));
        nextCycle();
        checkValue("loadDone", 0, 32'(loadDone));
        checkValue("loadDone pulse count", 1, donePulses);
        drainWrites();
        for (int w = 0; w < 256; w++) readCheck(9'(w));
    endtask

    task automatic issueFetch(input logic [4:0] row, input logic [4:0] col);
        logic [7:0] idx;
        logic [1:0] pal;
        expectTile(row, col, idx, pal);
        fetchStb   = 1'b1;
        tileRow    = row;
        tileCol    = col;
        pipeV[0]   = 1'b1;
        pipeIdx[0] = idx;
        pipePal[0] = pal;
        nextCycle();
    endtask

    // cpu write meets the first name strobe at the arbiter
    task automatic raceWrite(input logic [8:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        logic [31:0] nameData;
        loadStart = 1'b1;
        nextCycle();
        nameData = $random(seed);
        loadStb  = 1'b1;
        loadData = nameData;
        nextCycle();
        cpuWe     = be;
        cpuWrAddr = addr;
        cpuWrData = data;
        nextCycle();
        checkValue("grant", 32'(ntPkg::GNT_CPU), 32'(grant));
        nextCycle();
        checkValue("grant", 32'(ntPkg::GNT_NAME), 32'(grant));
        mergeShadow(addr, be, data);
        shadow[ntPkg::NameBase] = nameData;
        drainWrites();
        readCheck(addr);
        readCheck(ntPkg::NameBase);
    endtask

    // cpu holds the port every cycle, name strobes pile up
    task automatic burstWrites(input logic [8:0] base);
        logic [31:0] data;
        for (int k = 0; k < BurstLen; k++) begin
            data      = $random(seed);
            cpuWe     = 4'hF;
            cpuWrAddr = base + 9'(k);
            cpuWrData = data;
            shadow[base + 9'(k)] = data;
            loadStb   = 1'b1;
            loadData  = $random(seed);
            nextCycle();
        end
        drainWrites();
        checkValue("wrOverflow", 1, 32'(wrOverflow));
        for (int k = 0; k < BurstLen; k++) readCheck(base + 9'(k));
    endtask

    task automatic addStep(input tbOp_e op, input logic [8:0] addr, input logic [31:0] data,
                           input logic [3:0] be, input logic [4:0] row, input logic [4:0] col,
                           input logic expOvf);
        step_t s;
        s.op     = op;
        s.addr   = addr;
        s.data   = data;
        s.be     = be;
        s.row    = row;
        s.col    = col;
        s.expOvf = expOvf;
        steps.push_back(s);
    endtask

    initial begin
        clk_sel   = 1'b0;
        rstN      = 1'b0;
        cpuWe     = '0;
        cpuWrAddr = '0;
        cpuWrData = '0;
        cpuRdAddr = '0;
        loadStart = 1'b0;
        loadStb   = 1'b0;
        loadData  = '0;
        fetchStb  = 1'b0;
        tileRow   = '0;
        tileCol   = '0;
        for (int i = 0; i < 2; i++) begin
            pipeV[i]   = 1'b0;
            pipeIdx[i] = '0;
            pipePal[i] = '0;
        end

        // op, addr, data, be, row, col, expected overflow
        addStep(OP_LOAD, 0, 0, 0, 0, 0, 0);
        addStep(OP_CPUWR, 8, 32'hA1B2C3D4, 4'b1000, 0, 0, 0);
        addStep(OP_CPUWR, 9, 32'h11223344, 4'b0110, 0, 0, 0);
        addStep(OP_CPUWR, 240, 32'h5A5AA5A5, 4'b0001, 0, 0, 0);
        addStep(OP_CPUWR, 241, 32'hFFFF0000, 4'b1100, 0, 0, 0);
        addStep(OP_CPUWR, 100, 32'hDEADBEEF, 4'b0101, 0, 0, 0);
        addStep(OP_CPURD, 8, 0, 0, 0, 0, 0);
        addStep(OP_CPURD, 9, 0, 0, 0, 0, 0);
        addStep(OP_CPURD, 240, 0, 0, 0, 0, 0);
        addStep(OP_CPURD, 241, 0, 0, 0, 0, 0);
        addStep(OP_CPURD, 100, 0, 0, 0, 0, 0);
        addStep(OP_CPURD, 7, 0, 0, 0, 0, 0);
        // quadrant corners and the rewritten words
        addStep(OP_FETCH, 0, 0, 0, 1, 0, 0);
        addStep(OP_FETCH, 0, 0, 0, 1, 3, 0);
        addStep(OP_FETCH, 0, 0, 0, 0, 0, 0);
        addStep(OP_FETCH, 0, 0, 0, 0, 2, 0);
        addStep(OP_FETCH, 0, 0, 0, 2, 0, 0);
        addStep(OP_FETCH, 0, 0, 0, 2, 2, 0);
        addStep(OP_FETCH, 0, 0, 0, 3, 3, 0);
        addStep(OP_FETCH, 0, 0, 0, 29, 31, 0);
        addStep(OP_FETCH, 0, 0, 0, 14, 17, 0);
        addStep(OP_FETCH, 0, 0, 0, 6, 9, 0);
        addStep(OP_FETCH, 0, 0, 0, 28, 30, 0);
        addStep(OP_RACE, 5, 32'h0F0F0F0F, 4'b0011, 0, 0, 0);
        addStep(OP_BURST, 400, 0, 0, 0, 0, 1);
        cycleLimit = steps.size() * 300 + LoadCycles;

        repeat (8) @(negedge clk_sel);
        rstN = 1'b1;
        checkValue("tileValid", 0, 32'(tileValid));
        checkValue("loadDone", 0, 32'(loadDone));
        checkValue("wrOverflow", 0, 32'(wrOverflow));
        checkValue("grant", 32'(ntPkg::GNT_NONE), 32'(grant));

        foreach (steps[i]) begin
            case (steps[i].op)
                OP_LOAD:  loadAll();
                OP_CPUWR: writeCpu(steps[i].addr, steps[i].be, steps[i].data);
                OP_CPURD: readCheck(steps[i].addr);
                OP_FETCH: issueFetch(steps[i].row, steps[i].col);
                OP_RACE:  raceWrite(steps[i].addr, steps[i].be, steps[i].data);
                OP_BURST: burstWrites(steps[i].addr);
                default:  checkValue("step kind", 0, 1);
            endcase
            checkValue("wrOverflow", 32'(steps[i].expOvf), 32'(wrOverflow));
        end

        // overflow is sticky
        repeat (4) nextCycle();
        checkValue("wrOverflow", 1, 32'(wrOverflow));
        $display("Test passed");
        $finish;
    end

endmodule

// File: src.f
ntPkg.sv
nameTableRam.sv
ntWriteArbiter.sv
flashLoader.sv
tileFetch.sv
nameTableTop.sv
nameTableTb.sv

// File: Bender.yml
package:
  name: nametable

sources:
  - files:
      - ntPkg.sv
      - nameTableRam.sv
      - ntWriteArbiter.sv
      - flashLoader.sv
      - tileFetch.sv
      - nameTableTop.sv
  - target: simulation
    files:
      - nameTableTb.sv
